// File: source/par_cfg.svh
`ifndef PAR_CFG_SVH
`define PAR_CFG_SVH

// Number of worker cores sharing the global counter
// The prefix-sum logic scales from 2 to 8 cores
`define PAR_N_CORE 4

// Loop index width, indices are signed
`define PAR_GC_WIDTH 32

// Stride width, strides are unsigned and nonzero
`define PAR_GD_WIDTH 16

// Per-core accumulators and the reduced sum
// Wide enough that a few thousand large indices do not overflow
`define PAR_ACC_WIDTH 48

// Iteration counts, per core and total
`define PAR_CNT_WIDTH 24

`endif

// File: source/par_pkg.sv
`default_nettype none

`include "par_cfg.svh"

package par_pkg;

	// Loop index handed out by the global counter
	typedef logic signed [`PAR_GC_WIDTH-1:0] gc_t;

	// Loop stride
	typedef logic [`PAR_GD_WIDTH-1:0] gd_t;

	// Sum of indices, signed since the base may be negative
	typedef logic signed [`PAR_ACC_WIDTH-1:0] acc_t;

	// Number of iterations done
	typedef logic [`PAR_CNT_WIDTH-1:0] cnt_t;

	// Running count of requests, must reach PAR_N_CORE
	typedef logic [$clog2(`PAR_N_CORE+1)-1:0] req_sum_t;

	// Worker FSM
	typedef enum logic [1:0] {
		W_IDLE,
		W_FETCH,
		W_BUSY,
		W_ENDED
	} worker_state_t;

	// Parent controller FSM
	typedef enum logic [1:0] {
		C_IDLE,
		C_FORK,
		C_RUN,
		C_REDUCE
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: source/gc_dispenser.sv
`timescale 1ns/10ps
`default_nettype none

`include "par_cfg.svh"

module gc_dispenser (
	input logic clk,
	input logic rst_n,
	input logic issue_fork,
	input par_pkg::gc_t fork_gc,
	input par_pkg::gd_t fork_gd,
	input logic [`PAR_N_CORE-1:0] gc_req_valid,
	output par_pkg::gc_t gc_assign [`PAR_N_CORE]
);
	import par_pkg::*;

	gc_t gc;
	gd_t gd;
	gc_t gc_plus [`PAR_N_CORE+1];
	req_sum_t req_sum [`PAR_N_CORE+1];

	// Candidate indices, counter plus 0..N strides
	for (genvar i = 0; i <= `PAR_N_CORE; i++) begin : g_plus
		assign gc_plus[i] = gc + gc_t'(gd) * gc_t'(i);
	end

	// Prefix sum of requests from lower numbered cores
	always_comb begin
		req_sum[0] = '0;
		for (int i = 0; i < `PAR_N_CORE; i++) begin
			req_sum[i+1] = req_sum[i] + req_sum_t'(gc_req_valid[i]);
		end
	end

	// Each requester gets the slot matching its rank among this cycle's requests
	for (genvar i = 0; i < `PAR_N_CORE; i++) begin : g_assign
		assign gc_assign[i] = gc_plus[req_sum[i]];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			gc <= '0;
			gd <= '0;
		end else if (issue_fork) begin
			gc <= fork_gc;
			gd <= fork_gd;
		end else begin
			// Skip past every index given out this cycle
			gc <= gc_plus[req_sum[`PAR_N_CORE]];
		end
	end

	// Workers must be parked while the counter is reloaded
	a_no_req_on_fork: assert property (
		@(posedge clk) disable iff (!rst_n)
		issue_fork |-> gc_req_valid == '0
	);

endmodule

`default_nettype wire

// File: source/worker_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "par_cfg.svh"

module worker_core #(
	parameter int CORE_I = 0
) (
	input logic clk,
	input logic rst_n,
	input logic parallel,
	input logic issue_fork,
	input par_pkg::gc_t limit,
	input par_pkg::gc_t gc,
	output logic gc_req_valid,
	output logic ending,
	output par_pkg::acc_t acc,
	output par_pkg::cnt_t iter
);
	import par_pkg::*;

	worker_state_t state;
	gc_t cur_idx;
	logic [1:0] wait_cnt;
	logic in_range;
	logic work_done;

	// Signed limit test, done nowhere else
	assign in_range = gc < limit;

	assign gc_req_valid = state == W_FETCH;
	assign ending = state == W_ENDED;
	assign work_done = (state == W_BUSY) && (wait_cnt == 2'd0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= W_IDLE;
		end else if (!parallel) begin
			state <= W_IDLE;
		end else begin
			case (state)
				W_IDLE: state <= W_FETCH;
				W_FETCH: begin
					if (in_range) begin
						state <= W_BUSY;
					end else begin
						state <= W_ENDED;
					end
				end
				W_BUSY: begin
					if (work_done) begin
						state <= W_FETCH;
					end
				end
				// Stay ended until the parent drops parallel
				default: state <= W_ENDED;
			endcase
		end
	end

	// Index capture and busy countdown
	always_ff @(posedge clk) begin
		if (gc_req_valid) begin
			cur_idx <= gc;
			// Wrapping 2-bit add gives the mod 4
			wait_cnt <= gc[1:0] + 2'(CORE_I);
		end else if (state == W_BUSY) begin
			wait_cnt <= wait_cnt - 2'd1;
		end
	end

	// Private accumulator, cleared on every fork
	always_ff @(posedge clk) begin
		if (issue_fork) begin
			acc <= '0;
			iter <= '0;
		end else if (work_done) begin
			acc <= acc + acc_t'(cur_idx);
			iter <= iter + cnt_t'(1);
		end
	end

	// An ended worker takes no index and its result stays frozen
	a_no_req_after_end: assert property (
		@(posedge clk) disable iff (!rst_n)
		ending |=> !gc_req_valid && $stable(acc) && $stable(iter)
	);

	// Requests only while the parent has the loop running
	a_req_in_fetch: assert property (
		@(posedge clk) disable iff (!rst_n)
		gc_req_valid |-> (state == W_FETCH) && parallel
	);

endmodule

`default_nettype wire

// File: source/fork_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "par_cfg.svh"

module fork_control (
	input logic clk,
	input logic rst_n,
	input logic start,
	input par_pkg::gc_t base,
	input par_pkg::gd_t stride,
	input par_pkg::gc_t limit_in,
	input logic [`PAR_N_CORE-1:0] ending,
	input par_pkg::acc_t acc [`PAR_N_CORE],
	input par_pkg::cnt_t iter [`PAR_N_CORE],
	output logic issue_fork,
	output par_pkg::gc_t fork_gc,
	output par_pkg::gd_t fork_gd,
	output par_pkg::gc_t limit,
	output logic parallel,
	output logic busy,
	output logic done,
	output par_pkg::acc_t sum,
	output par_pkg::cnt_t count
);
	import par_pkg::*;

	ctrl_state_t state;
	logic all_ending;
	acc_t acc_total;
	cnt_t cnt_total;

	assign all_ending = &ending;

	assign issue_fork = state == C_FORK;
	assign parallel = state == C_RUN;
	assign busy = state != C_IDLE;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= C_IDLE;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				C_IDLE: begin
					// Start is only looked at here, so a start while busy is dropped
					if (start) begin
						state <= C_FORK;
					end
				end
				C_FORK: state <= C_RUN;
				C_RUN: begin
					if (all_ending) begin
						state <= C_REDUCE;
					end
				end
				default: begin
					state <= C_IDLE;
					done <= 1'b1;
				end
			endcase
		end
	end

	// Command latch
	always_ff @(posedge clk) begin
		if (state == C_IDLE && start) begin
			fork_gc <= base;
			fork_gd <= stride;
			limit <= limit_in;
		end
	end

	// Reduction tree over all workers
	always_comb begin
		acc_total = '0;
		cnt_total = '0;
		for (int i = 0; i < `PAR_N_CORE; i++) begin
			acc_total = acc_total + acc[i];
			cnt_total = cnt_total + iter[i];
		end
	end

	// Results held until the next reduction
	always_ff @(posedge clk) begin
		if (state == C_REDUCE) begin
			sum <= acc_total;
			count <= cnt_total;
		end
	end

	// Reduction only sees workers that are all still ended
	a_done_after_reduce: assert property (
		@(posedge clk) disable iff (!rst_n)
		done |-> $past(state == C_REDUCE && all_ending)
	);

endmodule

`default_nettype wire

// File: source/par_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "par_cfg.svh"

module par_top (
	input logic clk,
	input logic rst_n,
	input logic start,
	input par_pkg::gc_t base,
	input par_pkg::gd_t stride,
	input par_pkg::gc_t limit,
	output logic busy,
	output logic done,
	output par_pkg::acc_t sum,
	output par_pkg::cnt_t count
);
	import par_pkg::*;

	logic issue_fork;
	logic parallel;
	gc_t fork_gc;
	gd_t fork_gd;
	gc_t run_limit;
	gc_t gc_assign [`PAR_N_CORE];
	logic [`PAR_N_CORE-1:0] gc_req_valid;
	logic [`PAR_N_CORE-1:0] ending;
	acc_t acc [`PAR_N_CORE];
	cnt_t iter [`PAR_N_CORE];

	fork_control fork_control_inst (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.base(base),
		.stride(stride),
		.limit_in(limit),
		.ending(ending),
		.acc(acc),
		.iter(iter),
		.issue_fork(issue_fork),
		.fork_gc(fork_gc),
		.fork_gd(fork_gd),
		.limit(run_limit),
		.parallel(parallel),
		.busy(busy),
		.done(done),
		.sum(sum),
		.count(count)
	);

	gc_dispenser gc_dispenser_inst (
		.clk(clk),
		.rst_n(rst_n),
		.issue_fork(issue_fork),
		.fork_gc(fork_gc),
		.fork_gd(fork_gd),
		.gc_req_valid(gc_req_valid),
		.gc_assign(gc_assign)
	);

	for (genvar i = 0; i < `PAR_N_CORE; i++) begin : g_core
		worker_core #(
			.CORE_I(i)
		) worker_core_inst (
			.clk(clk),
			.rst_n(rst_n),
			.parallel(parallel),
			.issue_fork(issue_fork),
			.limit(run_limit),
			.gc(gc_assign[i]),
			.gc_req_valid(gc_req_valid[i]),
			.ending(ending[i]),
			.acc(acc[i]),
			.iter(iter[i])
		);
	end

endmodule

`default_nettype wire

// File: tests/par_tb.sv
`timescale 1ns/10ps
`default_nettype none

module par_tb;
	import par_pkg::*;

	localparam int MARGIN = 40;
	localparam int N_RAND = 20;

	logic clk;
	logic rst_n;
	logic start;
	gc_t base;
	gd_t stride;
	gc_t limit;
	logic busy;
	logic done;
	acc_t sum;
	cnt_t count;

	logic [15:0] lfsr;
	acc_t exp_sum;
	cnt_t exp_count;
	int tests_run;
	int errors;
	int done_seen;
	int cycles;
	int cycle_limit;
	gc_t t_base [$];
	gd_t t_stride [$];
	gc_t t_limit [$];
	bit t_stray [$];

	par_top par_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.base(base),
		.stride(stride),
		.limit(limit),
		.busy(busy),
		.done(done),
		.sum(sum),
		.count(count)
	);

	always #50 clk = ~clk;

	// Expected result by walking the loop one index at a time
	function automatic void ref_loop(input gc_t b, input gd_t s, input gc_t l,
			output acc_t r_sum, output cnt_t r_cnt);
		longint idx;
		idx = longint'(b);
		r_sum = '0;
		r_cnt = '0;
		while (idx < longint'(l)) begin
			r_sum = r_sum + acc_t'(idx);
			r_cnt = r_cnt + cnt_t'(1);
			idx = idx + longint'(s);
		end
	endfunction

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic add_test(input gc_t b, input gd_t s, input gc_t l, input bit stray);
		t_base.push_back(b);
		t_stride.push_back(s);
		t_limit.push_back(l);
		t_stray.push_back(stray);
	endtask

	// Result check on every done pulse
	always @(negedge clk) begin
		if (rst_n && done) begin
			assert (sum === exp_sum) else begin
				$display("CHECK FAILED: sum expected %h got %h", exp_sum, sum);
				errors++;
			end
			assert (count === exp_count) else begin
				$display("CHECK FAILED: count expected %h got %h", exp_count, count);
				errors++;
			end
			assert (busy === 1'b0) else begin
				$display("CHECK FAILED: busy expected %h got %h", 1'b0, busy);
				errors++;
			end
			done_seen++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout after %0d cycles, the run never finished", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic run_test(input gc_t b, input gd_t s, input gc_t l, input bit stray);
		int errs_before;
		int seen_before;
		errs_before = errors;
		seen_before = done_seen;
		ref_loop(b, s, l, exp_sum, exp_count);
		start = 1'b1;
		base = b;
		stride = s;
		limit = l;
		@(negedge clk);
		// Values after the start cycle must not matter
		start = 1'b0;
		base = ~b;
		stride = ~s;
		limit = ~l;
		assert (busy === 1'b1) else begin
			$display("CHECK FAILED: busy expected %h got %h", 1'b1, busy);
			errors++;
		end
		if (stray) begin
			repeat (2) @(negedge clk);
			assert (busy === 1'b1) else begin
				$display("CHECK FAILED: busy expected %h got %h", 1'b1, busy);
				errors++;
			end
			start = 1'b1;
			base = b + gc_t'(7);
			stride = s + gd_t'(1);
			limit = l + gc_t'(100);
			@(negedge clk);
			start = 1'b0;
		end
		wait (done_seen != seen_before);
		if (stray) begin
			repeat (12) @(negedge clk);
			assert (done_seen == seen_before + 1) else begin
				$display("extra done pulse after a start sent while busy");
				errors++;
			end
			assert (busy === 1'b0) else begin
				$display("CHECK FAILED: busy expected %h got %h", 1'b0, busy);
				errors++;
			end
		end
		tests_run++;
		$display("test %0d: base %0d stride %0d limit %0d, %0d iterations, %s",
			tests_run, b, s, l, exp_count, (errors == errs_before) ? "ok" : "mismatch");
	endtask

	initial begin
		logic [31:0] bits;
		gc_t rb;
		gd_t rs;
		acc_t tmp_sum;
		cnt_t tmp_cnt;
		int total;
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		base = '0;
		stride = '0;
		limit = '0;
		lfsr = 16'd11292;
		exp_sum = '0;
		exp_count = '0;
		tests_run = 0;
		errors = 0;
		done_seen = 0;
		cycles = 0;
		cycle_limit = 0;

		add_test(0, 16'd1, 40, 1'b0);
		// Empty loops
		add_test(10, 16'd3, 10, 1'b0);
		add_test(5, 16'd2, -3, 1'b0);
		// Negative base and wide gaps
		add_test(-100000, 16'd40000, 300000, 1'b0);
		add_test(-1000000, 16'd65535, 1000000, 1'b0);
		for (int i = 0; i < N_RAND; i++) begin
			take_bits(8, bits);
			rb = gc_t'($signed(bits[7:0]));
			take_bits(3, bits);
			rs = gd_t'(bits[2:0]) + gd_t'(1);
			take_bits(7, bits);
			add_test(rb, rs, rb + gc_t'(bits[6:0]) - gc_t'(8), 1'b0);
		end
		add_test(0, 16'd1, 60, 1'b1);
		// Large run then a small one, so the accumulators must restart from zero
		add_test(1000, 16'd3, 1100, 1'b0);
		add_test(0, 16'd1, 5, 1'b0);

		total = 10;
		foreach (t_base[i]) begin
			ref_loop(t_base[i], t_stride[i], t_limit[i], tmp_sum, tmp_cnt);
			total += int'(tmp_cnt) * 5 + MARGIN;
		end
		cycle_limit = total;

		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		foreach (t_base[i]) begin
			run_test(t_base[i], t_stride[i], t_limit[i], t_stray[i]);
		end

		$display("%0d tests run, %0d failed checks", tests_run, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+source
source/par_pkg.sv
source/gc_dispenser.sv
source/worker_core.sv
source/fork_control.sv
source/par_top.sv
tests/par_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= par_tb
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
FAIL_MSG ?= Simulation FAILED

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard source/*.sv source/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails when the log holds the fail message or the simulator exits with an error
run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
